// ==== hw/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// the fetch address counts 32-bit words, the byte offset is not carried
`define ICACHE_AW         32
`define ICACHE_SETS       16
`define ICACHE_WAYS       4
`define ICACHE_LINE_WORDS 4
`define ICACHE_APB_AW     8

// fields of the decoded fetch address
`define ICACHE_IDX_W $clog2(`ICACHE_SETS)
`define ICACHE_OFF_W $clog2(`ICACHE_LINE_WORDS)
`define ICACHE_TAG_W (`ICACHE_AW - `ICACHE_IDX_W - `ICACHE_OFF_W)

`endif

// ==== hw/cache_pkg.sv ====
`include "icache_defs.svh"

package cache_pkg;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] tag;
        logic [`ICACHE_IDX_W-1:0] index;
        logic [`ICACHE_OFF_W-1:0] word;
    } addr_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } fetch_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic [`ICACHE_AW-1:0] addr;  // word address of word 0 in the line
    } mem_ar_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        last;
    } mem_r_t;

    typedef logic [`ICACHE_LINE_WORDS-1:0][31:0] line_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REPLACE,
        REFILL
    } ctrl_state_t;

endpackage

// ==== hw/apb_pkg.sv ====
`include "icache_defs.svh"

package apb_pkg;

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`ICACHE_APB_AW-1:0] paddr;
        logic [31:0]               pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
    } apb_rsp_t;

    localparam logic [`ICACHE_APB_AW-1:0] REG_CTRL   = 'h00;  // bit 0 invalidates all
    localparam logic [`ICACHE_APB_AW-1:0] REG_HITS   = 'h04;
    localparam logic [`ICACHE_APB_AW-1:0] REG_MISSES = 'h08;

endpackage

// ==== hw/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic fetch_valid,
    input  logic hit,
    input  logic fill_done,
    input  logic flush_req,
    input  logic ar_ready,
    output logic req_ready,
    output logic ar_valid,
    output logic r_ready,
    output logic abuf_we,
    output logic way_sel_en,
    output logic tagv_we,
    output logic data_we,
    output logic inv_all,
    output logic rsp_valid,
    output logic hit_evt,
    output logic miss_evt
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t state_nxt;

    logic [`ICACHE_IDX_W-1:0] clr_cnt;
    logic                     clearing;
    logic                     flush_pending;
    logic                     flush_go;
    logic                     accept;

    assign accept   = fetch_valid && req_ready;
    assign flush_go = (state == cache_pkg::IDLE) && flush_pending && !clearing;
    assign abuf_we  = accept;
    assign inv_all  = clearing || flush_go;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // one pass over the sets after reset while requests are held off
    always_ff @(posedge clk) begin
        if (!rstn) begin
            clearing <= 1'b1;
            clr_cnt  <= '0;
        end else if (clearing) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (clr_cnt == '1) clearing <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            flush_pending <= 1'b0;
        end else if (flush_req) begin
            flush_pending <= 1'b1;
        end else if (flush_go) begin
            flush_pending <= 1'b0;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::IDLE: begin
                if (accept) state_nxt = cache_pkg::LOOKUP;
            end
            cache_pkg::LOOKUP: begin
                if (!hit) begin
                    state_nxt = cache_pkg::REPLACE;
                end else if (!accept) begin
                    state_nxt = cache_pkg::IDLE;
                end
            end
            cache_pkg::REPLACE: begin
                if (ar_ready) state_nxt = cache_pkg::REFILL;
            end
            cache_pkg::REFILL: begin
                if (fill_done) state_nxt = accept ? cache_pkg::LOOKUP : cache_pkg::IDLE;
            end
            default: state_nxt = cache_pkg::IDLE;
        endcase
    end

    always_comb begin
        req_ready  = 1'b0;
        ar_valid   = 1'b0;
        r_ready    = 1'b0;
        way_sel_en = 1'b0;
        tagv_we    = 1'b0;
        data_we    = 1'b0;
        rsp_valid  = 1'b0;
        hit_evt    = 1'b0;
        miss_evt   = 1'b0;
        case (state)
            cache_pkg::IDLE: begin
                req_ready = !clearing && !flush_pending;
            end
            cache_pkg::LOOKUP: begin
                way_sel_en = 1'b1;
                rsp_valid  = hit;
                hit_evt    = hit;
                miss_evt   = !hit;
                req_ready  = hit && !flush_pending;  // back-to-back hits
            end
            cache_pkg::REPLACE: begin
                ar_valid = 1'b1;
            end
            cache_pkg::REFILL: begin
                r_ready   = 1'b1;
                tagv_we   = fill_done;
                data_we   = fill_done;
                rsp_valid = fill_done;
                req_ready = fill_done && !flush_pending;
            end
            default: ;
        endcase
    end

    // a miss is only answered once its line has come in
    a_no_rsp_in_replace: assert property (@(posedge clk) disable iff (!rstn)
        (state == cache_pkg::REPLACE) |=> !rsp_valid);

    // a finished fill always reaches the victim way
    a_write_after_fill: assert property (@(posedge clk) disable iff (!rstn)
        fill_done |-> tagv_we);

endmodule

// ==== hw/icache_store.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_store (
    input  logic              clk,
    input  logic              rstn,
    input  cache_pkg::addr_t  req_addr,
    input  logic              abuf_we,
    input  logic              way_sel_en,
    input  logic              tagv_we,
    input  logic              data_we,
    input  logic              inv_all,
    input  cache_pkg::mem_r_t mem_r,
    input  logic              r_ready,
    output logic              hit,
    output logic              fill_done,
    output logic [31:0]       rsp_data,
    output logic [31:0]       ar_addr
);

    cache_pkg::addr_t         abuf;
    cache_pkg::line_t         rbuf;
    logic [`ICACHE_OFF_W-1:0] beat_cnt;
    logic                     beat;

    logic [`ICACHE_TAG_W-1:0] tag_mem   [`ICACHE_WAYS][`ICACHE_SETS];
    logic                     valid_mem [`ICACHE_WAYS][`ICACHE_SETS];
    cache_pkg::line_t         data_mem  [`ICACHE_WAYS][`ICACHE_SETS];
    logic [2:0]               plru      [`ICACHE_SETS];

    logic [`ICACHE_WAYS-1:0] hit_vec;
    logic [1:0]              hit_way;
    logic [1:0]              victim;

    // tree bit 0 picks the half, bits 1 and 2 the way inside it
    function automatic logic [1:0] plru_pick(logic [2:0] t);
        return t[0] ? {1'b1, t[2]} : {1'b0, t[1]};
    endfunction

    function automatic logic [2:0] plru_touch(logic [2:0] t, logic [1:0] w);
        logic [2:0] n;
        n    = t;
        n[0] = ~w[1];  // point away from the used half
        if (w[1]) begin
            n[2] = ~w[0];
        end else begin
            n[1] = ~w[0];
        end
        return n;
    endfunction

    always_ff @(posedge clk) begin
        if (abuf_we) abuf <= req_addr;
    end

    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_vec[w] = valid_mem[w][abuf.index] && (tag_mem[w][abuf.index] == abuf.tag);
            if (hit_vec[w]) hit_way = w[1:0];
        end
    end

    assign hit      = |hit_vec;
    assign ar_addr  = {abuf.tag, abuf.index, {`ICACHE_OFF_W{1'b0}}};
    assign rsp_data = data_we ? rbuf[abuf.word]              // refill answers from the buffer
                              : data_mem[hit_way][abuf.index][abuf.word];

    assign beat = mem_r.valid && r_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt  <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= beat && mem_r.last;
            if (beat) beat_cnt <= mem_r.last ? '0 : beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) rbuf[beat_cnt] <= mem_r.data;
    end

    always_ff @(posedge clk) begin
        if (way_sel_en) victim <= plru_pick(plru[abuf.index]);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < `ICACHE_SETS; s++) plru[s] <= '0;
        end else if (way_sel_en && hit) begin
            plru[abuf.index] <= plru_touch(plru[abuf.index], hit_way);
        end else if (tagv_we) begin
            plru[abuf.index] <= plru_touch(plru[abuf.index], victim);
        end
    end

    always_ff @(posedge clk) begin
        if (inv_all) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                for (int s = 0; s < `ICACHE_SETS; s++) valid_mem[w][s] <= 1'b0;
            end
        end else if (tagv_we) begin
            valid_mem[victim][abuf.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tagv_we) tag_mem[victim][abuf.index] <= abuf.tag;
        if (data_we) data_mem[victim][abuf.index] <= rbuf;
    end

    a_one_way_hits: assert property (@(posedge clk) disable iff (!rstn)
        way_sel_en |-> $onehot0(hit_vec));

endmodule

// ==== hw/icache_regs.sv ====
`timescale 1ns/1ps

module icache_regs (
    input  logic              clk,
    input  logic              rstn,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp,
    input  logic              hit_evt,
    input  logic              miss_evt,
    output logic              flush_req
);

    logic        access;
    logic        wr;
    logic [31:0] hits;
    logic [31:0] misses;
    logic [31:0] rdata;

    assign access = apb_req.psel && apb_req.penable;
    assign wr     = access && apb_req.pwrite;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            flush_req <= 1'b0;
        end else begin
            flush_req <= wr && (apb_req.paddr == apb_pkg::REG_CTRL) && apb_req.pwdata[0];
        end
    end

    // any write to a counter clears it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            hits <= '0;
        end else if (wr && (apb_req.paddr == apb_pkg::REG_HITS)) begin
            hits <= '0;
        end else if (hit_evt) begin
            hits <= hits + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            misses <= '0;
        end else if (wr && (apb_req.paddr == apb_pkg::REG_MISSES)) begin
            misses <= '0;
        end else if (miss_evt) begin
            misses <= misses + 1'b1;
        end
    end

    always_comb begin
        case (apb_req.paddr)
            apb_pkg::REG_HITS:   rdata = hits;
            apb_pkg::REG_MISSES: rdata = misses;
            default:             rdata = '0;  // ctrl reads back as zero
        endcase
    end

    assign apb_rsp = {rdata, access};  // no wait states

endmodule

// ==== hw/icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  cache_pkg::fetch_req_t fetch_req,
    output logic                  req_ready,
    output cache_pkg::fetch_rsp_t fetch_rsp,
    output cache_pkg::mem_ar_t    mem_ar,
    input  logic                  ar_ready,
    input  cache_pkg::mem_r_t     mem_r,
    output logic                  r_ready,
    input  apb_pkg::apb_req_t     apb_req,
    output apb_pkg::apb_rsp_t     apb_rsp
);

    logic        abuf_we;
    logic        way_sel_en;
    logic        tagv_we;
    logic        data_we;
    logic        inv_all;
    logic        hit;
    logic        fill_done;
    logic        hit_evt;
    logic        miss_evt;
    logic        flush_req;
    logic        ar_valid;
    logic        rsp_valid;
    logic [31:0] rsp_data;
    logic [31:0] ar_addr;

    assign fetch_rsp = {rsp_valid, rsp_data};
    assign mem_ar    = {ar_valid, ar_addr};

    icache_ctrl icache_ctrl_i (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_valid (fetch_req.valid),
        .hit         (hit),
        .fill_done   (fill_done),
        .flush_req   (flush_req),
        .ar_ready    (ar_ready),
        .req_ready   (req_ready),
        .ar_valid    (ar_valid),
        .r_ready     (r_ready),
        .abuf_we     (abuf_we),
        .way_sel_en  (way_sel_en),
        .tagv_we     (tagv_we),
        .data_we     (data_we),
        .inv_all     (inv_all),
        .rsp_valid   (rsp_valid),
        .hit_evt     (hit_evt),
        .miss_evt    (miss_evt)
    );

    icache_store icache_store_i (
        .clk        (clk),
        .rstn       (rstn),
        .req_addr   (fetch_req.addr),
        .abuf_we    (abuf_we),
        .way_sel_en (way_sel_en),
        .tagv_we    (tagv_we),
        .data_we    (data_we),
        .inv_all    (inv_all),
        .mem_r      (mem_r),
        .r_ready    (r_ready),
        .hit        (hit),
        .fill_done  (fill_done),
        .rsp_data   (rsp_data),
        .ar_addr    (ar_addr)
    );

    icache_regs icache_regs_i (
        .clk       (clk),
        .rstn      (rstn),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .hit_evt   (hit_evt),
        .miss_evt  (miss_evt),
        .flush_req (flush_req)
    );

endmodule

// ==== bench/icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 2000;

    logic                  clk;
    logic                  rstn;
    cache_pkg::fetch_req_t fetch_req;
    logic                  req_ready;
    cache_pkg::fetch_rsp_t fetch_rsp;
    cache_pkg::mem_ar_t    mem_ar;
    logic                  ar_ready;
    cache_pkg::mem_r_t     mem_r;
    logic                  r_ready;
    apb_pkg::apb_req_t     apb_req;
    apb_pkg::apb_rsp_t     apb_rsp;

    logic [31:0] mem_rng  = 32'h1ce2;
    logic [31:0] addr_rng = 32'h1ce2;
    logic [31:0] exp_q[$];
    logic [31:0] rsp_addr;
    int          err_count    = 0;
    int          tests_failed = 0;
    int          rsp_count    = 0;
    int          ar_count     = 0;

    icache_top icache_top_i (
        .clk       (clk),
        .rstn      (rstn),
        .fetch_req (fetch_req),
        .req_ready (req_ready),
        .fetch_rsp (fetch_rsp),
        .mem_ar    (mem_ar),
        .ar_ready  (ar_ready),
        .mem_r     (mem_r),
        .r_ready   (r_ready),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp)
    );

    always #5 clk = ~clk;

    // instruction word stored at a word address
    function automatic logic [31:0] mem_word(logic [31:0] addr);
        return addr ^ 32'hc0de_0000;
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] n;
        n = x ^ (x << 13);
        n = n ^ (n >> 17);
        n = n ^ (n << 5);
        return n;
    endfunction

    task automatic check_eq(logic [31:0] got, logic [31:0] exp, string msg);
        if (got !== exp) begin
            $display("FAIL @ %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(string name, int errs_before);
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    task automatic random_delay();
        int d;
        mem_rng = xorshift(mem_rng);
        d = mem_rng % 4;
        repeat (d) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one request, returns 1 ns after the accepting edge
    task automatic fetch(logic [31:0] addr);
        fetch_req.valid = 1'b1;
        fetch_req.addr  = addr;
        do begin
            @(negedge clk);
        end while (req_ready !== 1'b1);
        exp_q.push_back(addr);
        @(posedge clk);
        #1;
        fetch_req.valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (exp_q.size() != 0 && n < 100);
        if (exp_q.size() != 0) begin
            $display("response missing: %0d requests unanswered after %0d cycles",
                     exp_q.size(), n);
            err_count++;
            exp_q.delete();
        end
        #1;
    endtask

    task automatic apb_xfer(logic write, logic [`ICACHE_APB_AW-1:0] addr,
                            logic [31:0] wdata, output logic [31:0] rdata);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        do begin
            @(negedge clk);
        end while (apb_rsp.pready !== 1'b1);
        rdata = apb_rsp.prdata;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(logic [`ICACHE_APB_AW-1:0] addr, logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(logic [`ICACHE_APB_AW-1:0] addr, output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'h0, data);
    endtask

    // memory answers each line request with four beats
    initial begin : memory_model
        logic [31:0] base;
        forever begin
            @(negedge clk);
            if (rstn === 1'b1 && mem_ar.valid === 1'b1) begin
                base = mem_ar.addr;
                @(posedge clk);
                #1;
                random_delay();
                ar_ready = 1'b1;
                @(posedge clk);
                #1;
                ar_ready = 1'b0;
                for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
                    random_delay();
                    mem_r.valid = 1'b1;
                    mem_r.data  = mem_word(base + i);
                    mem_r.last  = (i == `ICACHE_LINE_WORDS - 1);
                    do begin
                        @(negedge clk);
                    end while (r_ready !== 1'b1);
                    @(posedge clk);
                    #1;
                    mem_r = '0;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rstn === 1'b1 && mem_ar.valid === 1'b1 && ar_ready) ar_count++;
    end

    // every response against the oldest accepted address
    always @(negedge clk) begin
        if (rstn === 1'b1 && fetch_rsp.valid === 1'b1) begin
            rsp_count++;
            if (exp_q.size() == 0) begin
                $display("unexpected response at %0t ns with no request waiting", $time);
                err_count++;
            end else begin
                rsp_addr = exp_q.pop_front();
                check_eq(fetch_rsp.data, mem_word(rsp_addr),
                         $sformatf("data for address %h", rsp_addr));
            end
        end
    end

    initial begin : main
        logic [31:0] v0;
        logic [31:0] v1;
        logic [31:0] a;
        int          ar0;
        int          errs0;
        int          n;
        clk       = 1'b0;
        rstn      = 1'b0;
        fetch_req = '0;
        ar_ready  = 1'b0;
        mem_r     = '0;
        apb_req   = '0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        errs0 = err_count;
        n = 0;
        while (req_ready !== 1'b1 && n < 20) begin
            check_eq({fetch_rsp.valid, mem_ar.valid, r_ready}, 0, "outputs idle after reset");
            @(posedge clk);
            #1;
            n++;
        end
        check_eq(req_ready, 1, "req_ready within 20 cycles");
        apb_read(apb_pkg::REG_HITS, v0);
        check_eq(v0, 0, "hits after reset");
        apb_read(apb_pkg::REG_MISSES, v0);
        check_eq(v0, 0, "misses after reset");
        report_test("reset", errs0);

        errs0 = err_count;
        n = rsp_count;
        for (int i = 0; i < 200; i++) begin
            addr_rng = xorshift(addr_rng);
            fetch(addr_rng & 32'h0000_01ff);  // 128 lines, twice the capacity
        end
        wait_drain();
        check_eq(rsp_count - n, 200, "one response per request");
        report_test("random reads", errs0);

        errs0 = err_count;
        a = 32'h0004_0010;
        apb_read(apb_pkg::REG_HITS, v0);
        ar0 = ar_count;
        fetch(a);
        wait_drain();
        check_eq(ar_count - ar0, 1, "line requests on a miss");
        ar0 = ar_count;
        fetch(a + 1);
        wait_drain();
        check_eq(ar_count - ar0, 0, "line requests on a hit");
        apb_read(apb_pkg::REG_HITS, v1);
        check_eq(v1 - v0, 1, "hit counter step");
        report_test("miss then hit", errs0);

        errs0 = err_count;
        apb_read(apb_pkg::REG_MISSES, v0);
        for (int t = 0; t < 4; t++) fetch(32'h0000_4014 + t * 32'h40);  // set 5
        wait_drain();
        apb_read(apb_pkg::REG_MISSES, v1);
        check_eq(v1 - v0, 4, "misses on first pass");
        v0 = v1;
        for (int t = 0; t < 4; t++) fetch(32'h0000_4014 + t * 32'h40);
        wait_drain();
        apb_read(apb_pkg::REG_MISSES, v1);
        check_eq(v1 - v0, 0, "misses on second pass");
        report_test("four ways", errs0);

        errs0 = err_count;
        ar0 = ar_count;
        apb_write(apb_pkg::REG_CTRL, 32'h1);
        apb_read(apb_pkg::REG_MISSES, v0);
        fetch(a);
        wait_drain();
        check_eq(ar_count - ar0, 1, "line requests after invalidate");
        apb_read(apb_pkg::REG_MISSES, v1);
        check_eq(v1 - v0, 1, "miss counter after invalidate");
        report_test("invalidate", errs0);

        errs0 = err_count;
        apb_write(apb_pkg::REG_HITS, 32'h1);
        apb_read(apb_pkg::REG_HITS, v0);
        check_eq(v0, 0, "hits after clear");
        apb_read(8'h0c, v0);
        check_eq(v0, 0, "unknown offset");
        report_test("registers", errs0);

        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== icache_top.f ====
+incdir+hw
hw/cache_pkg.sv
hw/apb_pkg.sv
hw/icache_ctrl.sv
hw/icache_store.sv
hw/icache_regs.sv
hw/icache_top.sv
bench/icache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= icache_tb
FLIST     ?= icache_top.f
BUILD     ?= obj_dir
VFLAGS    ?= --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD)
